/* hw/link_test_params.svh */
`ifndef LINK_TEST_PARAMS_SVH
`define LINK_TEST_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// widths
//////////////////////////////////////////////////////////////////////

// bus side
`define LT_ADDR_W 16
`define LT_DATA_W 32
// stream side
`define LT_LANE_W 16
`define LT_KEEP_W 2
// latency counter
`define LT_TIMER_W 32
// payload words per frame, last word carries tlast
`define LT_FRAME_WORDS 3

//////////////////////////////////////////////////////////////////////
// register map, low 16 bits of the bus address
//////////////////////////////////////////////////////////////////////

// latency results
`define LT_ADDR_LAT_1TO2 16'h0013
`define LT_ADDR_LAT_2TO1 16'h0014
// control
`define LT_ADDR_ENABLE 16'h0020
`define LT_ADDR_FSM_RESET 16'h0030
// channel 1 payload, receive history, receive status
`define LT_ADDR_CH1_DATA1 16'h0021
`define LT_ADDR_CH1_DATA2 16'h0022
`define LT_ADDR_CH1_DATA3 16'h0023
`define LT_ADDR_CH1_RDBK_DATA1 16'h0024
`define LT_ADDR_CH1_RDBK_DATA2 16'h0025
`define LT_ADDR_CH1_RDBK_DATA3 16'h0026
`define LT_ADDR_CH1_RDBK_STAT1 16'h0027
`define LT_ADDR_CH1_RDBK_STAT2 16'h0028
`define LT_ADDR_CH1_RDBK_STAT3 16'h0029
// channel 2, same layout one block up
`define LT_ADDR_CH2_DATA1 16'h0031
`define LT_ADDR_CH2_DATA2 16'h0032
`define LT_ADDR_CH2_DATA3 16'h0033
`define LT_ADDR_CH2_RDBK_DATA1 16'h0034
`define LT_ADDR_CH2_RDBK_DATA2 16'h0035
`define LT_ADDR_CH2_RDBK_DATA3 16'h0036
`define LT_ADDR_CH2_RDBK_STAT1 16'h0037
`define LT_ADDR_CH2_RDBK_STAT2 16'h0038
`define LT_ADDR_CH2_RDBK_STAT3 16'h0039

`endif

/* hw/link_test_pkg.sv */
`include "link_test_params.svh"

package link_test_pkg;

	//////////////////////////////////////////////////////////////////////
	// receive status word
	//////////////////////////////////////////////////////////////////////

	// one bus word, seen either as the raw readback value
	// or split into the link status fields
	typedef union packed {
		// raw view, what the bus returns
		logic [`LT_DATA_W-1:0] raw;
		// field view, top bit down
		struct packed {
			// unused upper part, always zero
			logic [20:0] zero_hi;
			// stream qualifiers of the captured word
			logic rx_valid;
			logic rx_last;
			// gap between last and keep
			logic [1:0] zero_mid;
			logic [`LT_KEEP_W-1:0] rx_keep;
			// link health at capture time
			logic hard_err;
			logic soft_err;
			logic frame_err;
			logic lane_up;
			logic channel_up;
		} fields;
	} link_status_t;

endpackage

/* hw/link_test_regs.sv */
`timescale 1ns/1ps
`include "link_test_params.svh"

module link_test_regs (
	input logic io_clk,
	input logic reset,
	// bus
	input logic io_sel,
	input logic io_sync,
	input logic [`LT_ADDR_W-1:0] io_addr,
	input logic io_rd_en,
	input logic io_wr_en,
	input logic [`LT_DATA_W-1:0] io_wr_data,
	output logic [`LT_DATA_W-1:0] io_rd_data,
	output logic io_rd_ack,
	// control and payload towards the senders
	output logic [1:0] ch_enable,
	output logic fsm_reset,
	output logic [`LT_LANE_W-1:0] ch1_data1,
	output logic [`LT_LANE_W-1:0] ch1_data2,
	output logic [`LT_LANE_W-1:0] ch1_data3,
	output logic [`LT_LANE_W-1:0] ch2_data1,
	output logic [`LT_LANE_W-1:0] ch2_data2,
	output logic [`LT_LANE_W-1:0] ch2_data3,
	// capture history
	input logic [`LT_LANE_W-1:0] ch1_rdbk_data1,
	input logic [`LT_LANE_W-1:0] ch1_rdbk_data2,
	input logic [`LT_LANE_W-1:0] ch1_rdbk_data3,
	input logic [`LT_LANE_W-1:0] ch2_rdbk_data1,
	input logic [`LT_LANE_W-1:0] ch2_rdbk_data2,
	input logic [`LT_LANE_W-1:0] ch2_rdbk_data3,
	input link_test_pkg::link_status_t ch1_rdbk_stat1,
	input link_test_pkg::link_status_t ch1_rdbk_stat2,
	input link_test_pkg::link_status_t ch1_rdbk_stat3,
	input link_test_pkg::link_status_t ch2_rdbk_stat1,
	input link_test_pkg::link_status_t ch2_rdbk_stat2,
	input link_test_pkg::link_status_t ch2_rdbk_stat3,
	// timers
	input logic [`LT_TIMER_W-1:0] lat_1to2,
	input logic [`LT_TIMER_W-1:0] lat_2to1
);

	logic wr_stb;
	logic rd_stb;
	logic [`LT_DATA_W-1:0] rd_mux;

	// 16-bit values go out zero-extended
	function automatic logic [`LT_DATA_W-1:0] zext_lane(input logic [`LT_LANE_W-1:0] v);
		zext_lane = {{(`LT_DATA_W-`LT_LANE_W){1'b0}}, v};
	endfunction

	// a bus access needs select and sync in the same cycle
	assign wr_stb = io_sel && io_sync && io_wr_en;
	assign rd_stb = io_sel && io_sync && io_rd_en;

	//////////////////////////////////////////////////////////////////////
	// writable registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge io_clk) begin
		if (reset) begin
			ch_enable <= 2'b00;
			fsm_reset <= 1'b0;
			ch1_data1 <= '0;
			ch1_data2 <= '0;
			ch1_data3 <= '0;
			ch2_data1 <= '0;
			ch2_data2 <= '0;
			ch2_data3 <= '0;
		end else if (wr_stb) begin
			case (io_addr)
				// bit 0 channel 1, bit 1 channel 2
				`LT_ADDR_ENABLE: ch_enable <= io_wr_data[1:0];
				`LT_ADDR_FSM_RESET: fsm_reset <= io_wr_data[0];
				`LT_ADDR_CH1_DATA1: ch1_data1 <= io_wr_data[`LT_LANE_W-1:0];
				`LT_ADDR_CH1_DATA2: ch1_data2 <= io_wr_data[`LT_LANE_W-1:0];
				`LT_ADDR_CH1_DATA3: ch1_data3 <= io_wr_data[`LT_LANE_W-1:0];
				`LT_ADDR_CH2_DATA1: ch2_data1 <= io_wr_data[`LT_LANE_W-1:0];
				`LT_ADDR_CH2_DATA2: ch2_data2 <= io_wr_data[`LT_LANE_W-1:0];
				`LT_ADDR_CH2_DATA3: ch2_data3 <= io_wr_data[`LT_LANE_W-1:0];
				// read-only or unmapped, write dropped
				default: ;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// readback
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (io_addr)
			`LT_ADDR_ENABLE: rd_mux = {{(`LT_DATA_W-2){1'b0}}, ch_enable};
			`LT_ADDR_FSM_RESET: rd_mux = {{(`LT_DATA_W-1){1'b0}}, fsm_reset};
			`LT_ADDR_CH1_DATA1: rd_mux = zext_lane(ch1_data1);
			`LT_ADDR_CH1_DATA2: rd_mux = zext_lane(ch1_data2);
			`LT_ADDR_CH1_DATA3: rd_mux = zext_lane(ch1_data3);
			`LT_ADDR_CH1_RDBK_DATA1: rd_mux = zext_lane(ch1_rdbk_data1);
			`LT_ADDR_CH1_RDBK_DATA2: rd_mux = zext_lane(ch1_rdbk_data2);
			`LT_ADDR_CH1_RDBK_DATA3: rd_mux = zext_lane(ch1_rdbk_data3);
			`LT_ADDR_CH1_RDBK_STAT1: rd_mux = ch1_rdbk_stat1.raw;
			`LT_ADDR_CH1_RDBK_STAT2: rd_mux = ch1_rdbk_stat2.raw;
			`LT_ADDR_CH1_RDBK_STAT3: rd_mux = ch1_rdbk_stat3.raw;
			`LT_ADDR_CH2_DATA1: rd_mux = zext_lane(ch2_data1);
			`LT_ADDR_CH2_DATA2: rd_mux = zext_lane(ch2_data2);
			`LT_ADDR_CH2_DATA3: rd_mux = zext_lane(ch2_data3);
			`LT_ADDR_CH2_RDBK_DATA1: rd_mux = zext_lane(ch2_rdbk_data1);
			`LT_ADDR_CH2_RDBK_DATA2: rd_mux = zext_lane(ch2_rdbk_data2);
			`LT_ADDR_CH2_RDBK_DATA3: rd_mux = zext_lane(ch2_rdbk_data3);
			`LT_ADDR_CH2_RDBK_STAT1: rd_mux = ch2_rdbk_stat1.raw;
			`LT_ADDR_CH2_RDBK_STAT2: rd_mux = ch2_rdbk_stat2.raw;
			`LT_ADDR_CH2_RDBK_STAT3: rd_mux = ch2_rdbk_stat3.raw;
			`LT_ADDR_LAT_1TO2: rd_mux = lat_1to2;
			`LT_ADDR_LAT_2TO1: rd_mux = lat_2to1;
			// unmapped reads as zero
			default: rd_mux = '0;
		endcase
	end

	// ack one cycle after the strobe, data held until the next read
	always_ff @(posedge io_clk) begin
		if (reset) begin
			io_rd_ack <= 1'b0;
			io_rd_data <= '0;
		end else begin
			io_rd_ack <= rd_stb;
			if (rd_stb)
				io_rd_data <= rd_mux;
		end
	end

endmodule

/* hw/frame_sender.sv */
`timescale 1ns/1ps
`include "link_test_params.svh"

module frame_sender (
	input logic io_clk,
	input logic reset,
	input logic fsm_reset,
	input logic enable,
	input logic [`LT_LANE_W-1:0] data1,
	input logic [`LT_LANE_W-1:0] data2,
	input logic [`LT_LANE_W-1:0] data3,
	output logic [`LT_LANE_W-1:0] tx_data,
	output logic tx_valid,
	output logic [`LT_KEEP_W-1:0] tx_keep,
	output logic tx_last
);

	localparam logic ST_IDLE = 1'b0;
	localparam logic ST_SEND = 1'b1;
	localparam logic [1:0] LAST_IDX = 2'(`LT_FRAME_WORDS - 1);

	logic state;
	// index of the word now on tx_data
	logic [1:0] idx;
	// set once enable was seen low, one frame per rising enable
	logic armed;
	logic start;
	logic advance;
	logic [`LT_LANE_W-1:0] next_word;

	assign start = (state == ST_IDLE) && enable && armed;
	// more words left in this frame
	assign advance = (state == ST_SEND) && (idx != LAST_IDX);

	// word to present at the next edge
	always_comb begin
		if (state == ST_IDLE)
			next_word = data1;
		else if (idx == 2'd0)
			next_word = data2;
		else
			next_word = data3;
	end

	//////////////////////////////////////////////////////////////////////
	// control
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge io_clk) begin
		if (reset || fsm_reset) begin
			state <= ST_IDLE;
			idx <= 2'd0;
			armed <= 1'b0;
			tx_valid <= 1'b0;
			tx_last <= 1'b0;
			tx_keep <= '0;
		end else begin
			// enable low re-arms, start consumes it
			if (!enable)
				armed <= 1'b1;
			else if (start)
				armed <= 1'b0;
			if (start) begin
				state <= ST_SEND;
				idx <= 2'd0;
				tx_valid <= 1'b1;
				tx_keep <= '1;
				tx_last <= (LAST_IDX == 2'd0);
			end else if (advance) begin
				idx <= idx + 2'd1;
				tx_valid <= 1'b1;
				tx_keep <= '1;
				// tlast rides on the final word only
				tx_last <= (idx + 2'd1 == LAST_IDX);
			end else begin
				state <= ST_IDLE;
				idx <= 2'd0;
				tx_valid <= 1'b0;
				tx_keep <= '0;
				tx_last <= 1'b0;
			end
		end
	end

	// payload
	always_ff @(posedge io_clk) begin
		if (start || advance)
			tx_data <= next_word;
	end

endmodule

/* hw/rx_capture.sv */
`timescale 1ns/1ps
`include "link_test_params.svh"

module rx_capture (
	input logic io_clk,
	input logic reset,
	input logic [`LT_LANE_W-1:0] rx_data,
	input logic rx_valid,
	input logic [`LT_KEEP_W-1:0] rx_keep,
	input logic rx_last,
	input logic hard_err,
	input logic soft_err,
	input logic frame_err,
	input logic lane_up,
	input logic channel_up,
	output logic [`LT_LANE_W-1:0] rdbk_data1,
	output logic [`LT_LANE_W-1:0] rdbk_data2,
	output logic [`LT_LANE_W-1:0] rdbk_data3,
	output link_test_pkg::link_status_t rdbk_stat1,
	output link_test_pkg::link_status_t rdbk_stat2,
	output link_test_pkg::link_status_t rdbk_stat3
);

	import link_test_pkg::*;

	link_status_t stat_new;

	// status of the incoming word, padding left at zero
	always_comb begin
		stat_new.raw = '0;
		stat_new.fields.rx_valid = rx_valid;
		stat_new.fields.rx_last = rx_last;
		stat_new.fields.rx_keep = rx_keep;
		stat_new.fields.hard_err = hard_err;
		stat_new.fields.soft_err = soft_err;
		stat_new.fields.frame_err = frame_err;
		stat_new.fields.lane_up = lane_up;
		stat_new.fields.channel_up = channel_up;
	end

	//////////////////////////////////////////////////////////////////////
	// three-deep history, slot 3 newest, slot 1 oldest
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge io_clk) begin
		if (reset) begin
			rdbk_data1 <= '0;
			rdbk_data2 <= '0;
			rdbk_data3 <= '0;
			rdbk_stat1 <= '0;
			rdbk_stat2 <= '0;
			rdbk_stat3 <= '0;
		end else if (rx_valid) begin
			rdbk_data3 <= rx_data;
			rdbk_data2 <= rdbk_data3;
			rdbk_data1 <= rdbk_data2;
			// status follows its word
			rdbk_stat3 <= stat_new;
			rdbk_stat2 <= rdbk_stat3;
			rdbk_stat1 <= rdbk_stat2;
		end
	end

endmodule

/* hw/latency_timer.sv */
`timescale 1ns/1ps
`include "link_test_params.svh"

module latency_timer (
	input logic io_clk,
	input logic reset,
	input logic fsm_reset,
	input logic start_valid,
	input logic stop_valid,
	output logic [`LT_TIMER_W-1:0] latency
);

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_COUNT = 2'd1;
	localparam logic [1:0] ST_DONE = 2'd2;

	logic [1:0] state;

	//////////////////////////////////////////////////////////////////////
	// tx valid to rx valid, in io_clk cycles
	//////////////////////////////////////////////////////////////////////

	// count starts at one on the edge that sees start,
	// so D stages of delay end up as D
	always_ff @(posedge io_clk) begin
		if (reset || fsm_reset) begin
			state <= ST_IDLE;
			latency <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					// rx activity before the first tx is ignored
					if (start_valid) begin
						latency <= {{(`LT_TIMER_W-1){1'b0}}, !stop_valid};
						state <= stop_valid ? ST_DONE : ST_COUNT;
					end
				end
				ST_COUNT: begin
					if (stop_valid)
						state <= ST_DONE;
					else
						latency <= latency + 1'b1;
				end
				// hold until reset or sender reset
				ST_DONE: state <= ST_DONE;
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

/* hw/link_test_top.sv */
`timescale 1ns/1ps
`include "link_test_params.svh"

module link_test_top (
	input logic io_clk,
	input logic reset,
	// bus
	input logic io_sel,
	input logic io_sync,
	input logic [`LT_ADDR_W-1:0] io_addr,
	input logic io_rd_en,
	input logic io_wr_en,
	input logic [`LT_DATA_W-1:0] io_wr_data,
	output logic [`LT_DATA_W-1:0] io_rd_data,
	output logic io_rd_ack,
	// channel 1 transmit
	output logic [`LT_LANE_W-1:0] tx_data_1,
	output logic tx_valid_1,
	output logic [`LT_KEEP_W-1:0] tx_keep_1,
	output logic tx_last_1,
	// channel 1 receive and link status
	input logic [`LT_LANE_W-1:0] rx_data_1,
	input logic rx_valid_1,
	input logic [`LT_KEEP_W-1:0] rx_keep_1,
	input logic rx_last_1,
	input logic hard_err_1,
	input logic soft_err_1,
	input logic frame_err_1,
	input logic lane_up_1,
	input logic channel_up_1,
	// channel 2 transmit
	output logic [`LT_LANE_W-1:0] tx_data_2,
	output logic tx_valid_2,
	output logic [`LT_KEEP_W-1:0] tx_keep_2,
	output logic tx_last_2,
	// channel 2 receive and link status
	input logic [`LT_LANE_W-1:0] rx_data_2,
	input logic rx_valid_2,
	input logic [`LT_KEEP_W-1:0] rx_keep_2,
	input logic rx_last_2,
	input logic hard_err_2,
	input logic soft_err_2,
	input logic frame_err_2,
	input logic lane_up_2,
	input logic channel_up_2
);

	import link_test_pkg::*;

	// control
	logic [1:0] ch_enable;
	logic fsm_reset;
	// payload registers
	logic [`LT_LANE_W-1:0] ch1_data1;
	logic [`LT_LANE_W-1:0] ch1_data2;
	logic [`LT_LANE_W-1:0] ch1_data3;
	logic [`LT_LANE_W-1:0] ch2_data1;
	logic [`LT_LANE_W-1:0] ch2_data2;
	logic [`LT_LANE_W-1:0] ch2_data3;
	// capture history
	logic [`LT_LANE_W-1:0] ch1_rdbk_data1;
	logic [`LT_LANE_W-1:0] ch1_rdbk_data2;
	logic [`LT_LANE_W-1:0] ch1_rdbk_data3;
	logic [`LT_LANE_W-1:0] ch2_rdbk_data1;
	logic [`LT_LANE_W-1:0] ch2_rdbk_data2;
	logic [`LT_LANE_W-1:0] ch2_rdbk_data3;
	link_status_t ch1_rdbk_stat1;
	link_status_t ch1_rdbk_stat2;
	link_status_t ch1_rdbk_stat3;
	link_status_t ch2_rdbk_stat1;
	link_status_t ch2_rdbk_stat2;
	link_status_t ch2_rdbk_stat3;
	// latency results
	logic [`LT_TIMER_W-1:0] lat_1to2;
	logic [`LT_TIMER_W-1:0] lat_2to1;

	//////////////////////////////////////////////////////////////////////
	// register block
	//////////////////////////////////////////////////////////////////////

	link_test_regs i_regs (
		.io_clk(io_clk),
		.reset(reset),
		.io_sel(io_sel),
		.io_sync(io_sync),
		.io_addr(io_addr),
		.io_rd_en(io_rd_en),
		.io_wr_en(io_wr_en),
		.io_wr_data(io_wr_data),
		.io_rd_data(io_rd_data),
		.io_rd_ack(io_rd_ack),
		.ch_enable(ch_enable),
		.fsm_reset(fsm_reset),
		.ch1_data1(ch1_data1),
		.ch1_data2(ch1_data2),
		.ch1_data3(ch1_data3),
		.ch2_data1(ch2_data1),
		.ch2_data2(ch2_data2),
		.ch2_data3(ch2_data3),
		.ch1_rdbk_data1(ch1_rdbk_data1),
		.ch1_rdbk_data2(ch1_rdbk_data2),
		.ch1_rdbk_data3(ch1_rdbk_data3),
		.ch2_rdbk_data1(ch2_rdbk_data1),
		.ch2_rdbk_data2(ch2_rdbk_data2),
		.ch2_rdbk_data3(ch2_rdbk_data3),
		.ch1_rdbk_stat1(ch1_rdbk_stat1),
		.ch1_rdbk_stat2(ch1_rdbk_stat2),
		.ch1_rdbk_stat3(ch1_rdbk_stat3),
		.ch2_rdbk_stat1(ch2_rdbk_stat1),
		.ch2_rdbk_stat2(ch2_rdbk_stat2),
		.ch2_rdbk_stat3(ch2_rdbk_stat3),
		.lat_1to2(lat_1to2),
		.lat_2to1(lat_2to1)
	);

	//////////////////////////////////////////////////////////////////////
	// senders, one per channel, shared sender reset
	//////////////////////////////////////////////////////////////////////

	frame_sender i_sender_1 (
		.io_clk(io_clk),
		.reset(reset),
		.fsm_reset(fsm_reset),
		.enable(ch_enable[0]),
		.data1(ch1_data1),
		.data2(ch1_data2),
		.data3(ch1_data3),
		.tx_data(tx_data_1),
		.tx_valid(tx_valid_1),
		.tx_keep(tx_keep_1),
		.tx_last(tx_last_1)
	);

	frame_sender i_sender_2 (
		.io_clk(io_clk),
		.reset(reset),
		.fsm_reset(fsm_reset),
		.enable(ch_enable[1]),
		.data1(ch2_data1),
		.data2(ch2_data2),
		.data3(ch2_data3),
		.tx_data(tx_data_2),
		.tx_valid(tx_valid_2),
		.tx_keep(tx_keep_2),
		.tx_last(tx_last_2)
	);

	//////////////////////////////////////////////////////////////////////
	// receive captures, sender reset leaves them alone
	//////////////////////////////////////////////////////////////////////

	rx_capture i_capture_1 (
		.io_clk(io_clk),
		.reset(reset),
		.rx_data(rx_data_1),
		.rx_valid(rx_valid_1),
		.rx_keep(rx_keep_1),
		.rx_last(rx_last_1),
		.hard_err(hard_err_1),
		.soft_err(soft_err_1),
		.frame_err(frame_err_1),
		.lane_up(lane_up_1),
		.channel_up(channel_up_1),
		.rdbk_data1(ch1_rdbk_data1),
		.rdbk_data2(ch1_rdbk_data2),
		.rdbk_data3(ch1_rdbk_data3),
		.rdbk_stat1(ch1_rdbk_stat1),
		.rdbk_stat2(ch1_rdbk_stat2),
		.rdbk_stat3(ch1_rdbk_stat3)
	);

	rx_capture i_capture_2 (
		.io_clk(io_clk),
		.reset(reset),
		.rx_data(rx_data_2),
		.rx_valid(rx_valid_2),
		.rx_keep(rx_keep_2),
		.rx_last(rx_last_2),
		.hard_err(hard_err_2),
		.soft_err(soft_err_2),
		.frame_err(frame_err_2),
		.lane_up(lane_up_2),
		.channel_up(channel_up_2),
		.rdbk_data1(ch2_rdbk_data1),
		.rdbk_data2(ch2_rdbk_data2),
		.rdbk_data3(ch2_rdbk_data3),
		.rdbk_stat1(ch2_rdbk_stat1),
		.rdbk_stat2(ch2_rdbk_stat2),
		.rdbk_stat3(ch2_rdbk_stat3)
	);

	//////////////////////////////////////////////////////////////////////
	// latency timers, tx of one channel against rx of the other
	//////////////////////////////////////////////////////////////////////

	latency_timer i_timer_1to2 (
		.io_clk(io_clk),
		.reset(reset),
		.fsm_reset(fsm_reset),
		.start_valid(tx_valid_1),
		.stop_valid(rx_valid_2),
		.latency(lat_1to2)
	);

	latency_timer i_timer_2to1 (
		.io_clk(io_clk),
		.reset(reset),
		.fsm_reset(fsm_reset),
		.start_valid(tx_valid_2),
		.stop_valid(rx_valid_1),
		.latency(lat_2to1)
	);

endmodule

/* verification/link_test_tb.sv */
`timescale 1ns/1ps
`include "link_test_params.svh"

module link_test_tb;

	import link_test_pkg::*;

	localparam int WAIT_LIMIT = 200;
	// window watched for an unwanted second frame
	localparam int QUIET_CYCLES = 12;

	// dut ports, names match the top level
	logic io_clk;
	logic reset;
	logic io_sel;
	logic io_sync;
	logic [`LT_ADDR_W-1:0] io_addr;
	logic io_rd_en;
	logic io_wr_en;
	logic [`LT_DATA_W-1:0] io_wr_data;
	logic [`LT_DATA_W-1:0] io_rd_data;
	logic io_rd_ack;
	logic [`LT_LANE_W-1:0] tx_data_1;
	logic tx_valid_1;
	logic [`LT_KEEP_W-1:0] tx_keep_1;
	logic tx_last_1;
	logic [`LT_LANE_W-1:0] rx_data_1;
	logic rx_valid_1;
	logic [`LT_KEEP_W-1:0] rx_keep_1;
	logic rx_last_1;
	logic hard_err_1;
	logic soft_err_1;
	logic frame_err_1;
	logic lane_up_1;
	logic channel_up_1;
	logic [`LT_LANE_W-1:0] tx_data_2;
	logic tx_valid_2;
	logic [`LT_KEEP_W-1:0] tx_keep_2;
	logic tx_last_2;
	logic [`LT_LANE_W-1:0] rx_data_2;
	logic rx_valid_2;
	logic [`LT_KEEP_W-1:0] rx_keep_2;
	logic rx_last_2;
	logic hard_err_2;
	logic soft_err_2;
	logic frame_err_2;
	logic lane_up_2;
	logic channel_up_2;

	// one case line, in column order
	logic [31:0] kind;
	logic [31:0] mask;
	logic [15:0] pay [6];
	logic [31:0] depth;
	logic [4:0] st1;
	logic [4:0] st2;
	logic [31:0] exp_lat_1to2;
	logic [31:0] exp_lat_2to1;
	logic [31:0] exp_stat3_1;
	logic [31:0] exp_stat3_2;

	integer seed;
	int fd;
	int n_fields;
	int case_errors;
	int cases_run;
	int cases_bad;
	int bad_lines;
	int cycle;
	int line_depth;
	// loopback delay lines, {valid, last, keep, data}
	logic [19:0] line_1 [16];
	logic [19:0] line_2 [16];
	// tx words seen per channel, {last, keep, data}, with cycle stamps
	logic [18:0] tx_word [2][8];
	int tx_at [2][8];
	int tx_cnt [2];
	int rx_cnt [2];

	link_test_top i_link_test_top (.*);

	initial begin
		io_clk = 1'b0;
		forever #4 io_clk = ~io_clk;
	end

	//////////////////////////////////////////////////////////////////////
	// loopback model and tx monitor
	//////////////////////////////////////////////////////////////////////

	initial begin : loopback
		int i;
		forever begin
			@(posedge io_clk);
			#1;
			cycle = cycle + 1;
			if (tx_valid_1 && tx_cnt[0] < 8) begin
				tx_word[0][tx_cnt[0]] = {tx_last_1, tx_keep_1, tx_data_1};
				tx_at[0][tx_cnt[0]] = cycle;
				tx_cnt[0] = tx_cnt[0] + 1;
			end
			if (tx_valid_2 && tx_cnt[1] < 8) begin
				tx_word[1][tx_cnt[1]] = {tx_last_2, tx_keep_2, tx_data_2};
				tx_at[1][tx_cnt[1]] = cycle;
				tx_cnt[1] = tx_cnt[1] + 1;
			end
			// one register stage per entry
			for (i = 15; i > 0; i--) begin
				line_1[i] = line_1[i-1];
				line_2[i] = line_2[i-1];
			end
			line_1[0] = {tx_valid_1, tx_last_1, tx_keep_1, tx_data_1};
			line_2[0] = {tx_valid_2, tx_last_2, tx_keep_2, tx_data_2};
			// crossed over, channel 1 out lands on channel 2 in
			{rx_valid_2, rx_last_2, rx_keep_2, rx_data_2} = line_1[line_depth];
			{rx_valid_1, rx_last_1, rx_keep_1, rx_data_1} = line_2[line_depth];
			if (rx_valid_1)
				rx_cnt[0] = rx_cnt[0] + 1;
			if (rx_valid_2)
				rx_cnt[1] = rx_cnt[1] + 1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////////////////////////

	task automatic abort_run(input string what);
		$display("timeout while waiting for %s", what);
		$display("SOME TESTS FAILED");
		$finish;
	endtask

	task automatic expect_equal(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("error %s: expected 0x%08h, got 0x%08h", name, exp, got);
			case_errors = case_errors + 1;
		end
	endtask

	task automatic note_failure(input string what);
		$display("%s", what);
		case_errors = case_errors + 1;
	endtask

	// payload register address by index, channel 1 first
	function automatic logic [15:0] data_addr(input int i);
		case (i)
			0: data_addr = `LT_ADDR_CH1_DATA1;
			1: data_addr = `LT_ADDR_CH1_DATA2;
			2: data_addr = `LT_ADDR_CH1_DATA3;
			3: data_addr = `LT_ADDR_CH2_DATA1;
			4: data_addr = `LT_ADDR_CH2_DATA2;
			default: data_addr = `LT_ADDR_CH2_DATA3;
		endcase
	endfunction

	// status of a captured word, bit positions as in the register map
	function automatic link_status_t status_word(input logic last, input logic [4:0] st);
		link_status_t w;
		w.raw = {21'b0, 1'b1, last, 2'b00, 2'b11, st};
		return w;
	endfunction

	// one-cycle strobe, no ack may follow a write
	task automatic bus_write(input logic [15:0] addr, input logic [31:0] data, input logic sync);
		@(posedge io_clk);
		#1;
		io_sel = 1'b1;
		io_sync = sync;
		io_wr_en = 1'b1;
		io_addr = addr;
		io_wr_data = data;
		@(posedge io_clk);
		#1;
		io_sel = 1'b0;
		io_sync = 1'b0;
		io_wr_en = 1'b0;
		if (io_rd_ack)
			note_failure($sformatf("read acknowledge after a write to 0x%04h", addr));
	endtask

	task automatic bus_read(input logic [15:0] addr, output logic [31:0] data);
		int waited;
		@(posedge io_clk);
		#1;
		io_sel = 1'b1;
		io_sync = 1'b1;
		io_rd_en = 1'b1;
		io_addr = addr;
		@(posedge io_clk);
		#1;
		io_sel = 1'b0;
		io_sync = 1'b0;
		io_rd_en = 1'b0;
		waited = 1;
		while (!io_rd_ack) begin
			if (waited == WAIT_LIMIT)
				abort_run("a read acknowledge");
			@(posedge io_clk);
			#1;
			waited = waited + 1;
		end
		if (waited != 1)
			note_failure($sformatf("read acknowledge came %0d cycles after the strobe", waited));
		data = io_rd_data;
		@(posedge io_clk);
		#1;
		if (io_rd_ack)
			note_failure("read acknowledge stayed high for more than one cycle");
	endtask

	task automatic read_expect(input logic [15:0] addr, input logic [31:0] exp);
		logic [31:0] got;
		bus_read(addr, got);
		expect_equal($sformatf("io_rd_data (addr 0x%04h)", addr), got, exp);
	endtask

	// select and read enable without sync
	task automatic read_without_sync(input logic [15:0] addr);
		int i;
		@(posedge io_clk);
		#1;
		io_sel = 1'b1;
		io_sync = 1'b0;
		io_rd_en = 1'b1;
		io_addr = addr;
		@(posedge io_clk);
		#1;
		io_sel = 1'b0;
		io_rd_en = 1'b0;
		for (i = 0; i < 3; i++) begin
			if (io_rd_ack)
				note_failure("read acknowledge for a strobe without io_sync");
			@(posedge io_clk);
			#1;
		end
	endtask

	// c is 0 for channel 1; a quiet channel must show nothing
	task automatic check_tx(input int c, input logic enabled);
		int k;
		if (!enabled && tx_cnt[c] != 0) begin
			note_failure($sformatf("disabled channel %0d sent %0d words", c + 1, tx_cnt[c]));
		end else if (enabled && tx_cnt[c] != 3) begin
			note_failure($sformatf("channel %0d sent %0d words, a frame has 3", c + 1,
				tx_cnt[c]));
		end else if (enabled) begin
			for (k = 0; k < 3; k++) begin
				expect_equal($sformatf("tx_data_%0d word %0d", c + 1, k + 1),
					{16'h0, tx_word[c][k][15:0]}, {16'h0, pay[c * 3 + k]});
				expect_equal($sformatf("tx_keep_%0d word %0d", c + 1, k + 1),
					{30'h0, tx_word[c][k][17:16]}, 32'h3);
				expect_equal($sformatf("tx_last_%0d word %0d", c + 1, k + 1),
					{31'h0, tx_word[c][k][18]}, {31'h0, k == 2});
				if (tx_at[c][k] != tx_at[c][0] + k)
					note_failure($sformatf("channel %0d word %0d not in the next cycle",
						c + 1, k + 1));
			end
		end
	endtask

	// capture c holds the words that started at pay[first]
	task automatic check_capture(input int c, input int first, input logic [4:0] st,
			input logic [31:0] stat3);
		int k;
		logic [15:0] d1;
		logic [15:0] s1;
		link_status_t mid;
		d1 = (c == 0) ? `LT_ADDR_CH1_RDBK_DATA1 : `LT_ADDR_CH2_RDBK_DATA1;
		s1 = (c == 0) ? `LT_ADDR_CH1_RDBK_STAT1 : `LT_ADDR_CH2_RDBK_STAT1;
		for (k = 0; k < 3; k++)
			read_expect(d1 + 16'(k), {16'h0, pay[first + k]});
		// older slots carry no last
		mid = status_word(1'b0, st);
		read_expect(s1, mid.raw);
		read_expect(s1 + 16'd1, mid.raw);
		read_expect(s1 + 16'd2, stat3);
	endtask

	//////////////////////////////////////////////////////////////////////
	// case kinds
	//////////////////////////////////////////////////////////////////////

	task automatic run_reg_case();
		int i;
		logic [31:0] r;
		// junk in the upper half, readback must be zero-extended
		for (i = 0; i < 6; i++) begin
			r = $random(seed);
			bus_write(data_addr(i), {r[15:0], pay[i]}, 1'b1);
		end
		for (i = 0; i < 6; i++)
			read_expect(data_addr(i), {16'h0, pay[i]});
		// holes in the map
		read_expect(16'h0015, 32'h0);
		read_expect(16'h002a, 32'h0);
		read_expect(16'h0040, 32'h0);
		read_without_sync(data_addr(0));
		bus_write(data_addr(0), {16'h0, ~pay[0]}, 1'b0);
		read_expect(data_addr(0), {16'h0, pay[0]});
	endtask

	task automatic run_frame_case();
		int i;
		int waited;
		logic [31:0] r;
		line_depth = depth;
		{hard_err_1, soft_err_1, frame_err_1, lane_up_1, channel_up_1} = st1;
		{hard_err_2, soft_err_2, frame_err_2, lane_up_2, channel_up_2} = st2;
		// enable low first so each sender re-arms
		bus_write(`LT_ADDR_ENABLE, 32'h0, 1'b1);
		for (i = 0; i < 6; i++) begin
			r = $random(seed);
			bus_write(data_addr(i), {r[15:0], pay[i]}, 1'b1);
		end
		tx_cnt[0] = 0;
		tx_cnt[1] = 0;
		rx_cnt[0] = 0;
		rx_cnt[1] = 0;
		bus_write(`LT_ADDR_ENABLE, mask, 1'b1);
		waited = 0;
		while ((mask[0] && (tx_cnt[0] < 3 || rx_cnt[1] < 3))
				|| (mask[1] && (tx_cnt[1] < 3 || rx_cnt[0] < 3))) begin
			if (waited == WAIT_LIMIT)
				abort_run("frames to come back through the loopback");
			@(posedge io_clk);
			#1;
			waited = waited + 1;
		end
		// same enable again, no new frame allowed
		bus_write(`LT_ADDR_ENABLE, mask, 1'b1);
		for (i = 0; i < QUIET_CYCLES; i++) begin
			@(posedge io_clk);
			#1;
		end
		check_tx(0, mask[0]);
		check_tx(1, mask[1]);
		if (mask[0])
			check_capture(1, 0, st2, exp_stat3_2);
		if (mask[1])
			check_capture(0, 3, st1, exp_stat3_1);
		read_expect(`LT_ADDR_LAT_1TO2, exp_lat_1to2);
		read_expect(`LT_ADDR_LAT_2TO1, exp_lat_2to1);
		// sender reset pulse clears both timers
		bus_write(`LT_ADDR_FSM_RESET, 32'h1, 1'b1);
		bus_write(`LT_ADDR_FSM_RESET, 32'h0, 1'b1);
		read_expect(`LT_ADDR_LAT_1TO2, 32'h0);
		read_expect(`LT_ADDR_LAT_2TO1, 32'h0);
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin : main
		int i;
		seed = 20599;
		reset = 1'b1;
		io_sel = 1'b0;
		io_sync = 1'b0;
		io_addr = '0;
		io_rd_en = 1'b0;
		io_wr_en = 1'b0;
		io_wr_data = '0;
		{rx_valid_1, rx_last_1, rx_keep_1, rx_data_1} = '0;
		{rx_valid_2, rx_last_2, rx_keep_2, rx_data_2} = '0;
		{hard_err_1, soft_err_1, frame_err_1, lane_up_1, channel_up_1} = '0;
		{hard_err_2, soft_err_2, frame_err_2, lane_up_2, channel_up_2} = '0;
		for (i = 0; i < 16; i++) begin
			line_1[i] = '0;
			line_2[i] = '0;
		end
		tx_cnt[0] = 0;
		tx_cnt[1] = 0;
		rx_cnt[0] = 0;
		rx_cnt[1] = 0;
		cycle = 0;
		line_depth = 1;
		cases_run = 0;
		cases_bad = 0;
		bad_lines = 0;
		repeat (2) @(posedge io_clk);
		#1;
		reset = 1'b0;
		fd = $fopen("verification/link_test_cases.txt", "r");
		if (fd == 0) begin
			$display("cannot open verification/link_test_cases.txt");
			$display("SOME TESTS FAILED");
		end else begin
			while (!$feof(fd)) begin
				n_fields = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h\n",
					kind, mask, pay[0], pay[1], pay[2], pay[3], pay[4], pay[5], depth,
					st1, st2, exp_lat_1to2, exp_lat_2to1, exp_stat3_1, exp_stat3_2);
				if (n_fields != 15) begin
					if (!$feof(fd)) begin
						$display("case file line %0d cannot be read", cases_run + 1);
						bad_lines = bad_lines + 1;
					end
					break;
				end
				case_errors = 0;
				if (kind == 0)
					run_reg_case();
				else
					run_frame_case();
				cases_run = cases_run + 1;
				if (case_errors == 0) begin
					$display("case %0d (%s): ok", cases_run, kind == 0 ? "registers" : "frame");
				end else begin
					cases_bad = cases_bad + 1;
					$display("case %0d (%s): %0d errors", cases_run,
						kind == 0 ? "registers" : "frame", case_errors);
				end
			end
			$fclose(fd);
			$display("%0d cases run, %0d clean, %0d with errors, %0d unreadable lines",
				cases_run, cases_run - cases_bad, cases_bad, bad_lines);
			if (cases_bad == 0 && bad_lines == 0 && cases_run > 0) begin
				$display("ALL TESTS PASSED");
			end else begin
				$display("SOME TESTS FAILED");
			end
		end
		$finish;
	end

endmodule

/* verification/link_test_cases.txt */
0 0 1234 5678 9abc def0 0f0f f0f0 0 00 00 0 0 0 0
1 3 1111 2222 3333 4444 5555 6666 1 03 03 1 1 663 663
0 0 ffff 0000 8001 7ffe aaaa 5555 0 00 00 0 0 0 0
1 3 a1a1 b2b2 c3c3 d4d4 e5e5 f6f6 2 03 1b 2 2 663 67b
1 1 0bad 0c0d 0e0f 1000 2000 3000 3 1f 03 3 0 0 663
1 2 4000 5000 6000 7001 7002 7003 4 10 00 0 4 670 0
0 0 0001 0002 0004 0008 0010 0020 0 00 00 0 0 0 0
1 3 dead beef cafe f00d babe face 5 04 08 5 5 664 668
1 3 0000 ffff 0000 ffff 0000 ffff 1 00 1f 1 1 660 67f
0 0 cafe beef dead f00d 1357 2468 0 00 00 0 0 0 0
1 3 1357 2468 369c 48d0 5a5a a5a5 6 0c 07 6 6 66c 667
1 1 8000 4000 2000 1000 0800 0400 7 13 0b 7 0 0 66b
1 2 0101 0202 0303 0404 0505 0606 8 1c 02 0 8 67c 0
0 0 7fff 8000 0100 00ff 3c3c c3c3 0 00 00 0 0 0 0
1 3 9999 8888 7777 6666 5555 4444 9 01 01 9 9 661 661
1 3 0f00 00f0 000f f000 0ff0 f00f a 1e 11 a a 67e 671
1 3 2b2b 3c3c 4d4d 5e5e 6f6f 7a7a c 06 18 c c 666 678
0 0 1111 2222 4444 8888 eeee dddd 0 00 00 0 0 0 0
1 1 abcd bcde cdef def0 ef01 f012 2 0a 15 2 0 0 675
1 2 1020 3040 5060 7080 90a0 b0c0 3 15 0a 0 3 675 0
1 3 fedc ba98 7654 3210 0123 4567 b 09 12 b b 669 672
0 0 a5a5 5a5a 0ff0 f00f 1248 8421 0 00 00 0 0 0 0
1 3 cccc 3333 aaaa 5555 9696 6969 4 1d 0e 4 4 67d 66e
1 3 0001 8000 7ffe 0002 4000 bffd 1 1f 1f 1 1 67f 67f

/* link_test.f */
+incdir+hw
hw/link_test_pkg.sv
hw/link_test_regs.sv
hw/frame_sender.sv
hw/rx_capture.sv
hw/latency_timer.sv
hw/link_test_top.sv
verification/link_test_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the link test bench with Verilator, judge the result from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal \
	-f link_test.f \
	--top-module link_test_tb \
	--Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vlink_test_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
	exit 1
fi

exit 0
